/* all.f */
+incdir+rtl
rtl/loader_pkg.sv
rtl/uart_byte_rx.sv
rtl/image_loader.sv
rtl/image_mem.sv
rtl/image_load_top.sv
dv/tb_clk_gen.sv
dv/image_load_tb.sv

/* dv/image_load_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "loader_params.svh"

module image_load_tb;

  localparam int DONE_TIMEOUT  = 20 * `LDR_CLKS_PER_BIT;
  localparam int RESET_TIMEOUT = 16;

  logic               rst;
  logic               clk;
  logic               uart_rx;
  loader_pkg::addr_t  pmem_raddr;
  loader_pkg::pword_t pmem_rdata;
  loader_pkg::addr_t  dmem_raddr;
  loader_pkg::dword_t dmem_rdata;
  loader_pkg::addr_t  pmem_size;
  logic               load_done;
  logic               cpu_hold;

  // what the memories should hold, dmem indexed by word
  loader_pkg::pword_t exp_pmem [8];
  loader_pkg::dword_t exp_dmem [8];

  logic [31:0] lcg_state;
  int          err_count;
  int          tests_run;
  int          bytes_left;
  logic        watch_hold;

  tb_clk_gen clk_gen_i (
    .rst (rst),
    .clk (clk)
  );

  image_load_top dut_i (
    .rst        (rst),
    .clk        (clk),
    .uart_rx    (uart_rx),
    .pmem_raddr (pmem_raddr),
    .pmem_rdata (pmem_rdata),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .pmem_size  (pmem_size),
    .load_done  (load_done),
    .cpu_hold   (cpu_hold)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_pword(input string name, input loader_pkg::pword_t got,
                             input loader_pkg::pword_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_dword(input string name, input loader_pkg::dword_t got,
                             input loader_pkg::dword_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input loader_pkg::addr_t got,
                            input loader_pkg::addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      err_count++;
    end
  endtask

  // start bit, data lsb first, stop bit
  task automatic send_byte(input loader_pkg::rx_byte_t b, input logic stop_ok);
    logic [9:0] frame;
    frame = {stop_ok, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge rst);
      uart_rx <= frame[i];
      repeat (`LDR_CLKS_PER_BIT - 1) @(posedge rst);
    end
    if (!stop_ok) begin  // one idle bit so the next start edge is seen
      @(posedge rst);
      uart_rx <= 1'b1;
      repeat (`LDR_CLKS_PER_BIT - 1) @(posedge rst);
    end
  endtask

  task automatic stream_byte(input loader_pkg::rx_byte_t b);
    send_byte(b, 1'b1);
    bytes_left--;
    if (watch_hold && bytes_left != 0) begin
      @(negedge rst);
      check_bit("cpu_hold", cpu_hold, 1'b1);
      check_bit("load_done", load_done, 1'b0);
    end
  endtask

  // sync, sizes high byte first, program triples, data pairs
  task automatic load_image(input int psize, input int dsize, input int bad_word,
                            input logic watch);
    logic [23:0] raw;
    watch_hold = watch;
    bytes_left = 5 + 3 * psize + 2 * dsize;
    send_byte(`LDR_SYNC_HI, 1'b1);
    stream_byte(`LDR_SYNC_LO);
    stream_byte(loader_pkg::rx_byte_t'(psize >> 8));
    stream_byte(loader_pkg::rx_byte_t'(psize));
    stream_byte(loader_pkg::rx_byte_t'(dsize >> 8));
    stream_byte(loader_pkg::rx_byte_t'(dsize));
    for (int i = 0; i < psize; i++) begin
      lcg_state = lcg_next(lcg_state);
      raw = lcg_state[31:8];
      stream_byte(raw[23:16]);
      if (i == bad_word)
        send_byte(~raw[15:8], 1'b0);  // low stop bit
      stream_byte(raw[15:8]);
      stream_byte(raw[7:0]);
      exp_pmem[i] = raw[17:0];  // upper 6 bits of the triple are dropped
    end
    for (int j = 0; j < dsize; j++) begin
      lcg_state = lcg_next(lcg_state);
      stream_byte(lcg_state[31:24]);
      stream_byte(lcg_state[23:16]);
      exp_dmem[j] = lcg_state[31:16];
    end
  endtask

  task automatic wait_load_done();
    int n;
    for (n = 0; n < DONE_TIMEOUT; n++) begin
      @(negedge rst);
      if (load_done && !cpu_hold)
        break;
    end
    if (n == DONE_TIMEOUT) begin
      $display("Timeout at %0t: load_done did not rise after the image was sent", $time);
      err_count++;
    end
  endtask

  task automatic verify_pmem(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge rst);
      pmem_raddr <= loader_pkg::addr_t'(i);
      @(posedge rst);  // one cycle read latency
      @(negedge rst);
      check_pword($sformatf("pmem[%0d]", i), pmem_rdata, exp_pmem[i]);
    end
  endtask

  task automatic verify_dmem(input int count);
    loader_pkg::addr_t a;
    for (int j = 0; j < count; j++) begin
      a = loader_pkg::addr_t'(`LDR_DMEM_BASE + 2 * j);
      @(posedge rst);
      dmem_raddr <= a;
      @(posedge rst);
      @(negedge rst);
      check_dword($sformatf("dmem[%h]", a), dmem_rdata, exp_dmem[j]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    $display("test %-20s %s (%0d errors)", name,
             (err_count == errs_before) ? "passed" : "FAILED", err_count - errs_before);
  endtask

  task automatic test_reset_values();
    int errs_before;
    int n;
    errs_before = err_count;
    for (n = 0; n < RESET_TIMEOUT; n++) begin
      @(negedge rst);
      if (!clk)
        break;
    end
    if (n == RESET_TIMEOUT) begin
      $display("Timeout at %0t: reset was never released", $time);
      err_count++;
    end
    check_bit("load_done", load_done, 1'b1);
    check_bit("cpu_hold", cpu_hold, 1'b0);
    check_pword("pmem_rdata", pmem_rdata, '0);
    check_dword("dmem_rdata", dmem_rdata, '0);
    report_test("reset values", errs_before);
  endtask

  task automatic test_program_load();
    int errs_before;
    errs_before = err_count;
    load_image(5, 3, -1, 1'b0);
    wait_load_done();
    check_addr("pmem_size", pmem_size, loader_pkg::addr_t'(5));
    verify_pmem(5);
    report_test("program load", errs_before);
  endtask

  task automatic test_data_load();
    int errs_before;
    errs_before = err_count;
    verify_dmem(3);
    report_test("data load", errs_before);
  endtask

  task automatic test_hold_and_sync();
    loader_pkg::rx_byte_t noise [8];
    int errs_before;
    errs_before = err_count;
    noise = '{8'h12, 8'h55, 8'h3C, 8'hAA, 8'hAA, 8'h55, 8'h55, 8'h00};
    foreach (noise[i]) begin
      send_byte(noise[i], 1'b1);
      @(negedge rst);
      check_bit("load_done", load_done, 1'b1);
      check_bit("cpu_hold", cpu_hold, 1'b0);
    end
    verify_pmem(5);
    verify_dmem(3);
    load_image(5, 3, -1, 1'b1);
    wait_load_done();
    verify_pmem(5);
    verify_dmem(3);
    report_test("hold and sync", errs_before);
  endtask

  // smaller image, bad frame inside program word 1
  task automatic test_reload_and_framing();
    int errs_before;
    errs_before = err_count;
    load_image(3, 2, 1, 1'b0);
    wait_load_done();
    check_addr("pmem_size", pmem_size, loader_pkg::addr_t'(3));
    verify_pmem(5);
    verify_dmem(3);
    report_test("reload and framing", errs_before);
  endtask

  initial begin
    uart_rx    <= 1'b1;
    pmem_raddr <= '0;
    dmem_raddr <= '0;
    lcg_state  = 32'd78927;
    err_count  = 0;
    tests_run  = 0;
    test_reset_values();
    test_program_load();
    test_data_load();
    test_hold_and_sync();
    test_reload_and_framing();
    $display("%0d tests run, %0d errors", tests_run, err_count);
    if (err_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen (
  output logic rst,  // clock
  output logic clk   // reset, active high
);

  initial begin
    rst = 1'b0;
    forever #4 rst = ~rst;  // 8 ns period
  end

  // reset held over two rising edges
  initial begin
    clk <= 1'b1;
    repeat (2) @(posedge rst);
    clk <= 1'b0;
  end

endmodule

`default_nettype wire

/* rtl/image_load_top.sv */
`default_nettype none
`timescale 1ns/100ps

module image_load_top (
  input  logic               rst,  // clock
  input  logic               clk,  // async reset, active high
  input  logic               uart_rx,
  input  loader_pkg::addr_t  pmem_raddr,
  output loader_pkg::pword_t pmem_rdata,
  input  loader_pkg::addr_t  dmem_raddr,
  output loader_pkg::dword_t dmem_rdata,
  output loader_pkg::addr_t  pmem_size,
  output logic               load_done,
  output logic               cpu_hold
);

  loader_pkg::rx_byte_t rx_byte;
  logic                 rx_valid;
  loader_pkg::pmem_wr_t pmem_wr;
  loader_pkg::dmem_wr_t dmem_wr;

  uart_byte_rx rx_i (
    .rst      (rst),
    .clk      (clk),
    .rx       (uart_rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  image_loader loader_i (
    .rst       (rst),
    .clk       (clk),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .pmem_wr   (pmem_wr),
    .dmem_wr   (dmem_wr),
    .pmem_size (pmem_size),
    .load_done (load_done),
    .cpu_hold  (cpu_hold)
  );

  // cpu side reads go straight to the arrays
  image_mem mem_i (
    .rst        (rst),
    .clk        (clk),
    .pmem_wr    (pmem_wr),
    .dmem_wr    (dmem_wr),
    .pmem_raddr (pmem_raddr),
    .pmem_rdata (pmem_rdata),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata)
  );

endmodule

`default_nettype wire

/* rtl/image_loader.sv */
`default_nettype none
`timescale 1ns/100ps

`include "loader_params.svh"

module image_loader (
  input  logic                 rst,  // clock
  input  logic                 clk,  // async reset, active high
  input  loader_pkg::rx_byte_t rx_byte,
  input  logic                 rx_valid,
  output loader_pkg::pmem_wr_t pmem_wr,
  output loader_pkg::dmem_wr_t dmem_wr,
  output loader_pkg::addr_t    pmem_size,
  output logic                 load_done,
  output logic                 cpu_hold
);

  loader_pkg::img_state_t state;
  loader_pkg::addr_t      addr;
  loader_pkg::addr_t      dmem_size;
  loader_pkg::addr_t      dmem_end;
  loader_pkg::pword_t     shift;
  logic [1:0]             byte_phase;
  logic                   last_byte;
  logic                   word_done;
  logic                   sync_seen;
  logic                   sync_hit;

  // dmem size counts words, addresses step by two
  assign dmem_end = `LDR_DMEM_BASE + (dmem_size << 1);

  assign sync_hit = state == loader_pkg::WAIT && rx_valid && sync_seen &&
                    rx_byte == `LDR_SYNC_LO;

  always_comb begin
    case (state)
      loader_pkg::PMEM: last_byte = byte_phase == 2'd2;
      default:          last_byte = byte_phase == 2'd1;
    endcase
  end

  // 55 then aa, anything else restarts the match
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      sync_seen <= 1'b0;
    else if (state != loader_pkg::WAIT)
      sync_seen <= 1'b0;
    else if (rx_valid)
      sync_seen <= rx_byte == `LDR_SYNC_HI;
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state <= loader_pkg::WAIT;
    end else begin
      case (state)
        loader_pkg::WAIT:
          if (sync_hit)
            state <= loader_pkg::META;
        loader_pkg::META:
          if (word_done && addr == `LDR_ADDR_WIDTH'd1)
            state <= loader_pkg::PMEM;
        loader_pkg::PMEM:
          if (addr == pmem_size)
            state <= loader_pkg::DMEM;
        loader_pkg::DMEM:
          if (addr == dmem_end)
            state <= loader_pkg::FIN;
        default:
          state <= loader_pkg::WAIT;
      endcase
    end
  end

  // bytes per field: 2 meta, 3 pmem, 2 dmem
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      byte_phase <= 2'd0;
      word_done  <= 1'b0;
    end else begin
      word_done <= 1'b0;
      if (state == loader_pkg::WAIT || state == loader_pkg::FIN) begin
        byte_phase <= 2'd0;
      end else if (rx_valid) begin
        if (last_byte) begin
          byte_phase <= 2'd0;
          word_done  <= 1'b1;
        end else begin
          byte_phase <= byte_phase + 2'd1;
        end
      end
    end
  end

  // last 18 bits received
  always_ff @(posedge rst) begin
    if (rx_valid)
      shift <= {shift[9:0], rx_byte};
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pmem_size <= '0;
      dmem_size <= '0;
    end else if (state == loader_pkg::META && word_done) begin
      if (addr == `LDR_ADDR_WIDTH'd0)
        pmem_size <= shift[`LDR_ADDR_WIDTH-1:0];
      else
        dmem_size <= shift[`LDR_ADDR_WIDTH-1:0];
    end
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      addr <= '0;
    end else begin
      case (state)
        loader_pkg::META:
          if (word_done)
            addr <= (addr == `LDR_ADDR_WIDTH'd1) ? '0 : addr + `LDR_ADDR_WIDTH'd1;
        loader_pkg::PMEM:
          if (addr == pmem_size)
            addr <= `LDR_DMEM_BASE;
          else if (word_done)
            addr <= addr + `LDR_ADDR_WIDTH'd1;
        loader_pkg::DMEM:
          if (addr == dmem_end)
            addr <= '0;
          else if (word_done)
            addr <= addr + `LDR_ADDR_WIDTH'd2;
        default:
          addr <= '0;
      endcase
    end
  end

  // write lands the cycle after the last byte strobe
  assign pmem_wr.en   = word_done && state == loader_pkg::PMEM;
  assign pmem_wr.addr = addr;
  assign pmem_wr.data = shift;

  assign dmem_wr.en   = word_done && state == loader_pkg::DMEM;
  assign dmem_wr.addr = addr;
  assign dmem_wr.data = shift[`LDR_DWORD_WIDTH-1:0];

  assign cpu_hold  = state inside {loader_pkg::META, loader_pkg::PMEM, loader_pkg::DMEM};
  assign load_done = ~cpu_hold;  // also high in fin

endmodule

`default_nettype wire

/* rtl/image_mem.sv */
`default_nettype none
`timescale 1ns/100ps

`include "loader_params.svh"

module image_mem (
  input  logic                 rst,  // clock
  input  logic                 clk,  // async reset, active high
  input  loader_pkg::pmem_wr_t pmem_wr,
  input  loader_pkg::dmem_wr_t dmem_wr,
  input  loader_pkg::addr_t    pmem_raddr,
  output loader_pkg::pword_t   pmem_rdata,
  input  loader_pkg::addr_t    dmem_raddr,
  output loader_pkg::dword_t   dmem_rdata
);

  loader_pkg::pword_t pmem [`LDR_PMEM_DEPTH];
  loader_pkg::dword_t dmem [`LDR_DMEM_DEPTH];

  logic [`LDR_ADDR_WIDTH-2:0] dmem_widx;
  logic [`LDR_ADDR_WIDTH-2:0] dmem_ridx;

  // byte address to word index
  assign dmem_widx = dmem_wr.addr[`LDR_ADDR_WIDTH-1:1];
  assign dmem_ridx = dmem_raddr[`LDR_ADDR_WIDTH-1:1];

  always_ff @(posedge rst) begin
    if (pmem_wr.en)
      pmem[pmem_wr.addr] <= pmem_wr.data;
  end

  always_ff @(posedge rst) begin
    if (dmem_wr.en)
      dmem[dmem_widx] <= dmem_wr.data;
  end

  // read before write on a same-word collision
  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      pmem_rdata <= '0;
    else
      pmem_rdata <= pmem[pmem_raddr];
  end

  always_ff @(posedge rst or posedge clk) begin
    if (clk)
      dmem_rdata <= '0;
    else
      dmem_rdata <= dmem[dmem_ridx];
  end

endmodule

`default_nettype wire

/* rtl/loader_params.svh */
`ifndef LOADER_PARAMS_SVH
`define LOADER_PARAMS_SVH

// loader address, pmem word index and dmem byte address
`define LDR_ADDR_WIDTH   10
`define LDR_BYTE_WIDTH   8
`define LDR_PWORD_WIDTH  18
`define LDR_DWORD_WIDTH  16

// words per memory
`define LDR_PMEM_DEPTH   1024
`define LDR_DMEM_DEPTH   512   // covers the whole byte address space

// uart bit time in clock cycles
`define LDR_CLKS_PER_BIT 16

`define LDR_SYNC_HI      8'h55
`define LDR_SYNC_LO      8'hAA

`define LDR_DMEM_BASE    `LDR_ADDR_WIDTH'h100  // first data word

`endif

/* rtl/loader_pkg.sv */
`default_nettype none

`include "loader_params.svh"

package loader_pkg;

  typedef logic [`LDR_ADDR_WIDTH-1:0]  addr_t;
  typedef logic [`LDR_BYTE_WIDTH-1:0]  rx_byte_t;
  typedef logic [`LDR_PWORD_WIDTH-1:0] pword_t;
  typedef logic [`LDR_DWORD_WIDTH-1:0] dword_t;

  // image load phases
  typedef enum logic [2:0] {
    WAIT,  // idle, looking for 55 aa
    META,  // pmem size then dmem size
    PMEM,
    DMEM,
    FIN    // one cycle, load complete
  } img_state_t;

  // program memory write, word addressed
  typedef struct packed {
    logic   en;
    addr_t  addr;
    pword_t data;
  } pmem_wr_t;

  // data memory write, byte addressed
  typedef struct packed {
    logic   en;
    addr_t  addr;
    dword_t data;
  } dmem_wr_t;

endpackage

`default_nettype wire

/* rtl/uart_byte_rx.sv */
`default_nettype none
`timescale 1ns/100ps

`include "loader_params.svh"

module uart_byte_rx (
  input  logic                 rst,  // clock
  input  logic                 clk,  // async reset, active high
  input  logic                 rx,
  output loader_pkg::rx_byte_t rx_byte,
  output logic                 rx_valid
);

  localparam int CNT_W = $clog2(`LDR_CLKS_PER_BIT) + 1;
  localparam int HALF  = `LDR_CLKS_PER_BIT / 2;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             start_edge;
  logic             bit_mid;
  logic             start_mid;

  // two flop synchronizer, line idles high
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;
  assign start_mid  = cnt == CNT_W'(HALF - 1);
  assign bit_mid    = cnt == CNT_W'(`LDR_CLKS_PER_BIT - 1);  // one full bit past last mid

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (start_edge)
            state <= RX_START;
        end
        RX_START: begin
          if (start_mid) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA;  // high at mid = glitch
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        RX_DATA: begin
          if (bit_mid) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7)
              state <= RX_STOP;
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        RX_STOP: begin
          if (bit_mid) begin
            cnt      <= '0;
            rx_valid <= rx_sync;  // framing error drops the byte
            state    <= RX_IDLE;
          end else begin
            cnt <= cnt + CNT_W'(1);
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge rst) begin
    if (state == RX_DATA && bit_mid)
      rx_byte <= {rx_sync, rx_byte[7:1]};
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the image loader testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f all.f \
  --top-module image_load_tb -o sim_image_load || exit 1

out=$(./obj_dir/sim_image_load)
echo "$out"
echo "$out" | grep -q "^Everything OK$" && exit 0 || exit 1
